/* bus_map_pkg.sv */
package bus_map_pkg;

    // RAM window, one 32-bit word per 4-byte step
    localparam logic [31:0] ram_base = 32'h0000_1000;
    localparam int ram_words = 1024;

    // Words preloaded from the hex image
    localparam int ram_init_words = 16;

    // Single-word peripheral registers
    localparam logic [31:0] key_addr = 32'h0000_8000;
    localparam logic [31:0] uart_addr = 32'h0000_8008;
    localparam logic [31:0] sd_addr_reg = 32'h0000_8010;
    localparam logic [31:0] sd_read_reg = 32'h0000_8018;
    localparam logic [31:0] sd_avail_reg = 32'h0000_8020;

    // SD sector buffer, byte addressed
    localparam logic [31:0] sd_buf_base = 32'h0000_9000;
    localparam int sd_buf_bytes = 512;
    localparam int sd_idx_w = $clog2(sd_buf_bytes);

    // Decoded target of a bus access
    typedef enum logic [2:0] {
        region_none,
        region_ram,
        region_key,
        region_uart,
        region_sd_addr,
        region_sd_read,
        region_sd_avail,
        region_sd_buf
    } region_e;

endpackage

/* bus_txn_pkg.sv */
package bus_txn_pkg;

    localparam int addr_w = 32;
    localparam int data_w = 64;

    // Word offset for RAM, byte offset for the SD buffer
    localparam int off_w = 10;

    // Request as presented by the CPU data bus
    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
        logic              we;
        logic              re;
    } bus_req_t;

    // Request after address decode
    typedef struct packed {
        bus_map_pkg::region_e region;
        logic [off_w-1:0]     offset;
        logic [data_w-1:0]    wdata;
        logic                 we;
        logic                 re;
    } dec_req_t;

    // Peripheral side of a read result, RAM word travels separately
    typedef struct packed {
        bus_map_pkg::region_e region;
        logic [data_w-1:0]    data;
    } rsp_t;

endpackage

/* bus_stage_if.sv */
`timescale 1ns/1ns

interface bus_stage_if #(
    parameter type payload_t = logic
);

    // One-cycle strobe per item, no ready
    logic     valid;
    payload_t payload;

    modport src (
        output valid,
        output payload
    );

    modport dst (
        input valid,
        input payload
    );

endinterface

/* bus_decode_stage.sv */
`timescale 1ns/1ns

module bus_decode_stage (
    input  logic                  CLOCK_50,
    input  logic                  KEY0,
    input  bus_txn_pkg::bus_req_t req,
    bus_stage_if.src              dec
);
    import bus_map_pkg::*;
    import bus_txn_pkg::*;

    logic [addr_w-1:0] ram_rel;
    logic [addr_w-1:0] buf_rel;
    dec_req_t          next_item;

    assign ram_rel = req.addr - ram_base;
    assign buf_rel = req.addr - sd_buf_base;

    always_comb begin
        next_item.region = region_none;
        next_item.offset = '0;
        next_item.wdata = req.wdata;
        next_item.we = req.we;
        next_item.re = req.re;

        if (req.addr >= ram_base && req.addr < ram_base + addr_w'(4 * ram_words)) begin
            next_item.region = region_ram;
            next_item.offset = ram_rel[off_w+1:2];
        end else if (req.addr >= sd_buf_base &&
                     req.addr < sd_buf_base + addr_w'(sd_buf_bytes)) begin
            next_item.region = region_sd_buf;
            next_item.offset = off_w'(buf_rel[sd_idx_w-1:0]);
        end else begin
            case (req.addr)
                key_addr:     next_item.region = region_key;
                uart_addr:    next_item.region = region_uart;
                sd_addr_reg:  next_item.region = region_sd_addr;
                sd_read_reg:  next_item.region = region_sd_read;
                sd_avail_reg: next_item.region = region_sd_avail;
                default:      next_item.region = region_none;
            endcase
        end
    end

    // Either enable starts an item
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            dec.valid <= 1'b0;
        end else begin
            dec.valid <= req.re | req.we;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        dec.payload <= next_item;
    end

endmodule

/* bus_access_stage.sv */
`timescale 1ns/1ns

module bus_access_stage (
    input  logic                             CLOCK_50,
    input  logic                             KEY0,
    bus_stage_if.dst                         dec,
    bus_stage_if.src                         rsp,
    output logic [31:0]                      ram_q,
    input  logic [7:0]                       key_ascii,
    output logic [bus_map_pkg::sd_idx_w-1:0] sd_index,
    input  logic [7:0]                       sd_byte,
    input  logic                             sd_avail,
    output logic                             uart_write,
    output logic [7:0]                       uart_data,
    output logic                             sd_rd_start,
    output logic [31:0]                      sd_sector
);
    import bus_map_pkg::*;
    import bus_txn_pkg::*;

    logic [31:0]       mem [ram_words];
    dec_req_t          item;
    rsp_t              next_rsp;
    logic [data_w-1:0] periph_data;
    logic              do_write;
    logic              do_read;

    initial begin
        $readmemh("ram_init.hex", mem, 0, ram_init_words - 1);
    end

    assign item = dec.payload;
    assign do_write = dec.valid & item.we;
    assign do_read = dec.valid & item.re;

    // SD buffer answers combinationally on the byte index
    assign sd_index = item.offset[sd_idx_w-1:0];

    // Read-only registers, zero-extended to the bus width
    always_comb begin
        case (item.region)
            region_key:      periph_data = data_w'(key_ascii);
            region_sd_avail: periph_data = data_w'(sd_avail);
            region_sd_buf:   periph_data = data_w'(sd_byte);
            default:         periph_data = '0;
        endcase
    end

    assign next_rsp.region = item.region;
    assign next_rsp.data = periph_data;

    // Word RAM, write and read both land on this edge
    always_ff @(posedge CLOCK_50) begin
        if (do_write && item.region == region_ram) begin
            mem[item.offset] <= item.wdata[31:0];
        end
        if (do_read && item.region == region_ram) begin
            ram_q <= mem[item.offset];
        end
    end

    always_ff @(posedge CLOCK_50) begin
        rsp.payload <= next_rsp;
        if (do_write && item.region == region_uart) begin
            uart_data <= item.wdata[7:0];
        end
    end

    // Strobes and the sector register
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            rsp.valid <= 1'b0;
            uart_write <= 1'b0;
            sd_rd_start <= 1'b0;
            sd_sector <= '0;
        end else begin
            rsp.valid <= do_read;
            uart_write <= do_write && item.region == region_uart;
            sd_rd_start <= do_write && item.region == region_sd_read;
            if (do_write && item.region == region_sd_addr) begin
                sd_sector <= item.wdata[31:0];
            end
        end
    end

endmodule

/* sd_sector_buffer.sv */
`timescale 1ns/1ns

module sd_sector_buffer (
    input  logic                             CLOCK_50,
    input  logic                             KEY0,
    input  logic                             byte_valid,
    input  logic [7:0]                       byte_in,
    input  logic                             restart,
    input  logic [bus_map_pkg::sd_idx_w-1:0] rd_index,
    output logic [7:0]                       rd_byte,
    output logic                             available
);
    import bus_map_pkg::*;

    logic [7:0]          store [sd_buf_bytes];
    logic [sd_idx_w-1:0] wr_index;
    logic                last_byte;

    assign last_byte = wr_index == sd_idx_w'(sd_buf_bytes - 1);

    // Byte store, read port is asynchronous
    always_ff @(posedge CLOCK_50) begin
        if (byte_valid && !restart) begin
            store[wr_index] <= byte_in;
        end
    end

    assign rd_byte = store[rd_index];

    // A new read start drops any partly filled sector
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            wr_index <= '0;
            available <= 1'b0;
        end else if (restart) begin
            wr_index <= '0;
            available <= 1'b0;
        end else if (byte_valid) begin
            // Index wraps to zero after the last byte
            wr_index <= wr_index + 1'b1;
            if (last_byte) begin
                available <= 1'b1;
            end
        end
    end

endmodule

/* key_event_latch.sv */
`timescale 1ns/1ns

module key_event_latch (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic       key_valid,
    input  logic [7:0] key_ascii_in,
    input  logic       irq_ack,
    output logic [7:0] key_ascii,
    output logic [3:0] irq_vector
);

    logic new_key;

    // Zero codes are key releases or unmapped keys
    assign new_key = key_valid && key_ascii_in != 8'd0;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            key_ascii <= 8'd0;
            irq_vector <= 4'd0;
        end else begin
            if (new_key) begin
                key_ascii <= key_ascii_in;
            end
            // A key in the ack cycle keeps the interrupt raised
            if (new_key) begin
                irq_vector <= 4'd1;
            end else if (irq_ack && irq_vector != 4'd0) begin
                irq_vector <= 4'd0;
            end
        end
    end

endmodule

/* bus_response_stage.sv */
`timescale 1ns/1ns

module bus_response_stage (
    input  logic                           CLOCK_50,
    input  logic                           KEY0,
    bus_stage_if.dst                       rsp,
    input  logic [31:0]                    ram_q,
    output logic [bus_txn_pkg::data_w-1:0] read_data,
    output logic                           read_done
);
    import bus_map_pkg::*;
    import bus_txn_pkg::*;

    rsp_t              item;
    logic [data_w-1:0] sel_data;

    assign item = rsp.payload;

    // RAM word arrives on its own port
    always_comb begin
        case (item.region)
            region_ram:  sel_data = {32'd0, ram_q};
            region_none: sel_data = '0;
            default:     sel_data = item.data;
        endcase
    end

    always_ff @(posedge CLOCK_50) begin
        if (rsp.valid) begin
            read_data <= sel_data;
        end
    end

    // One done per read item, unmapped ones included
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            read_done <= 1'b0;
        end else begin
            read_done <= rsp.valid;
        end
    end

endmodule

/* board_bus.sv */
`timescale 1ns/1ns

module board_bus (
    input  logic                           CLOCK_50,
    input  logic                           KEY0,
    input  logic [bus_txn_pkg::addr_w-1:0] bus_address,
    input  logic [bus_txn_pkg::data_w-1:0] bus_write_data,
    input  logic                           bus_write_enable,
    input  logic                           bus_read_enable,
    input  logic                           key_valid,
    input  logic [7:0]                     key_ascii,
    input  logic                           irq_ack,
    input  logic                           sd_byte_valid,
    input  logic [7:0]                     sd_byte,
    output logic [bus_txn_pkg::data_w-1:0] bus_read_data,
    output logic                           bus_read_done,
    output logic [3:0]                     irq_vector,
    output logic                           uart_write,
    output logic [7:0]                     uart_data,
    output logic                           sd_rd_start,
    output logic [31:0]                    sd_sector
);
    import bus_map_pkg::*;
    import bus_txn_pkg::*;

    bus_req_t            req;
    logic [31:0]         ram_q;
    logic [7:0]          key_code;
    logic [sd_idx_w-1:0] sd_index;
    logic [7:0]          buf_byte;
    logic                sd_available;

    bus_stage_if #(.payload_t(dec_req_t)) dec_if ();
    bus_stage_if #(.payload_t(rsp_t)) rsp_if ();

    assign req.addr = bus_address;
    assign req.wdata = bus_write_data;
    assign req.we = bus_write_enable;
    assign req.re = bus_read_enable;

    bus_decode_stage u_decode (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .req      (req),
        .dec      (dec_if.src)
    );

    bus_access_stage u_access (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .dec         (dec_if.dst),
        .rsp         (rsp_if.src),
        .ram_q       (ram_q),
        .key_ascii   (key_code),
        .sd_index    (sd_index),
        .sd_byte     (buf_byte),
        .sd_avail    (sd_available),
        .uart_write  (uart_write),
        .uart_data   (uart_data),
        .sd_rd_start (sd_rd_start),
        .sd_sector   (sd_sector)
    );

    bus_response_stage u_response (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .rsp       (rsp_if.dst),
        .ram_q     (ram_q),
        .read_data (bus_read_data),
        .read_done (bus_read_done)
    );

    // Read start from the bus also rearms the sector fill
    sd_sector_buffer u_sd_buffer (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .byte_valid (sd_byte_valid),
        .byte_in    (sd_byte),
        .restart    (sd_rd_start),
        .rd_index   (sd_index),
        .rd_byte    (buf_byte),
        .available  (sd_available)
    );

    key_event_latch u_key_latch (
        .CLOCK_50     (CLOCK_50),
        .KEY0         (KEY0),
        .key_valid    (key_valid),
        .key_ascii_in (key_ascii),
        .irq_ack      (irq_ack),
        .key_ascii    (key_code),
        .irq_vector   (irq_vector)
    );

endmodule

/* tb_board_bus.sv */
`timescale 1ns/1ns

module tb_board_bus;
    import bus_map_pkg::*;
    import bus_txn_pkg::*;

    localparam int ram_pairs = 200;
    localparam int buf_reads = 64;
    // Stimulus takes about 1100 cycles
    localparam int max_cycles = 4000;

    logic              CLOCK_50;
    logic              KEY0;
    logic [addr_w-1:0] bus_address;
    logic [data_w-1:0] bus_write_data;
    logic              bus_write_enable;
    logic              bus_read_enable;
    logic              key_valid;
    logic [7:0]        key_ascii;
    logic              irq_ack;
    logic              sd_byte_valid;
    logic [7:0]        sd_byte;
    logic [data_w-1:0] bus_read_data;
    logic              bus_read_done;
    logic [3:0]        irq_vector;
    logic              uart_write;
    logic [7:0]        uart_data;
    logic              sd_rd_start;
    logic [31:0]       sd_sector;

    // Reference model state
    logic [31:0]       ram_model [ram_words];
    logic [7:0]        sd_model [sd_buf_bytes];
    logic [7:0]        key_model;
    logic              avail_model;
    logic [3:0]        exp_irq;
    logic [7:0]        exp_uart_data;
    logic [31:0]       exp_sector;
    logic [data_w-1:0] exp_q [$];
    logic [data_w-1:0] exp_data;
    logic              uart_req;
    logic              sd_start_req;
    logic              sd_sector_req;
    int                err_count;
    int                reads_done;
    int                cycle_count;

    board_bus u_board_bus (.*);

    assign uart_req = bus_write_enable && bus_address == uart_addr;
    assign sd_start_req = bus_write_enable && bus_address == sd_read_reg;
    assign sd_sector_req = bus_write_enable && bus_address == sd_addr_reg;

    initial begin
        CLOCK_50 = 1'b0;
        forever #2 CLOCK_50 = ~CLOCK_50;
    end

    // Expected data for the read whose done is due at the next edge
    always @(negedge CLOCK_50) begin
        if (bus_read_done && exp_q.size() != 0) begin
            exp_data = exp_q.pop_front();
            reads_done++;
        end
    end

    a_reset_idle: assert property (@(posedge CLOCK_50) $rose(KEY0) |->
        (!bus_read_done && !uart_write && !sd_rd_start && irq_vector == 4'd0 && sd_sector == 0))
    else begin
        err_count++;
        $display("Outputs were not idle when reset was released");
    end

    a_read_timing: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        bus_read_done == $past(bus_read_enable, 3))
    else begin
        err_count++;
        $display("FAIL bus_read_done: got %h expected %h",
                 $sampled(bus_read_done), !$sampled(bus_read_done));
    end

    a_read_data: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        bus_read_done |-> bus_read_data == exp_data)
    else begin
        err_count++;
        $display("FAIL bus_read_data: got %h expected %h", $sampled(bus_read_data), exp_data);
    end

    a_uart_pulse: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        uart_write == $past(uart_req, 2))
    else begin
        err_count++;
        $display("FAIL uart_write: got %h expected %h",
                 $sampled(uart_write), !$sampled(uart_write));
    end

    a_uart_data: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        uart_write |-> uart_data == exp_uart_data)
    else begin
        err_count++;
        $display("FAIL uart_data: got %h expected %h", $sampled(uart_data), exp_uart_data);
    end

    a_sd_start: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        sd_rd_start == $past(sd_start_req, 2))
    else begin
        err_count++;
        $display("FAIL sd_rd_start: got %h expected %h",
                 $sampled(sd_rd_start), !$sampled(sd_rd_start));
    end

    a_sd_sector: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        $past(sd_sector_req, 2) |-> sd_sector == exp_sector)
    else begin
        err_count++;
        $display("FAIL sd_sector: got %h expected %h", $sampled(sd_sector), exp_sector);
    end

    a_irq: assert property (@(posedge CLOCK_50) disable iff (!KEY0) irq_vector == exp_irq)
    else begin
        err_count++;
        $display("FAIL irq_vector: got %h expected %h", $sampled(irq_vector), exp_irq);
    end

    function automatic logic [63:0] expected_read(input logic [31:0] addr);
        logic [31:0] ram_rel;
        logic [31:0] buf_rel;
        logic [63:0] value;
        ram_rel = addr - ram_base;
        buf_rel = addr - sd_buf_base;
        value = '0;
        if (addr >= ram_base && addr < ram_base + 32'(4 * ram_words)) begin
            value = {32'd0, ram_model[ram_rel[11:2]]};
        end else if (addr >= sd_buf_base && addr < sd_buf_base + 32'(sd_buf_bytes)) begin
            value = {56'd0, sd_model[buf_rel[8:0]]};
        end else if (addr == key_addr) begin
            value = {56'd0, key_model};
        end else if (addr == sd_avail_reg) begin
            value = {63'd0, avail_model};
        end
        return value;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge CLOCK_50);
        #1;
    endtask

    task automatic drive_write(input logic [31:0] addr, input logic [63:0] data);
        logic [31:0] ram_rel;
        ram_rel = addr - ram_base;
        bus_address = addr;
        bus_write_data = data;
        bus_write_enable = 1'b1;
        if (addr >= ram_base && addr < ram_base + 32'(4 * ram_words)) begin
            ram_model[ram_rel[11:2]] = data[31:0];
        end
        if (addr == uart_addr) begin
            exp_uart_data = data[7:0];
        end
        if (addr == sd_addr_reg) begin
            exp_sector = data[31:0];
        end
        if (addr == sd_read_reg) begin
            avail_model = 1'b0;
        end
        wait_cycles(1);
        bus_write_enable = 1'b0;
    endtask

    task automatic drive_read(input logic [31:0] addr);
        bus_address = addr;
        bus_read_enable = 1'b1;
        exp_q.push_back(expected_read(addr));
        wait_cycles(1);
        bus_read_enable = 1'b0;
    endtask

    task automatic pulse_key(input logic valid, input logic [7:0] code, input logic ack);
        key_valid = valid;
        key_ascii = code;
        irq_ack = ack;
        wait_cycles(1);
        key_valid = 1'b0;
        irq_ack = 1'b0;
        // New key wins over a same-cycle acknowledge
        if (valid && code != 8'd0) begin
            key_model = code;
            exp_irq = 4'd1;
        end else if (ack) begin
            exp_irq = 4'd0;
        end
    endtask

    task automatic stream_sector();
        int i;
        for (i = 0; i < sd_buf_bytes; i++) begin
            sd_byte = 8'($urandom);
            sd_byte_valid = 1'b1;
            sd_model[i] = sd_byte;
            wait_cycles(1);
        end
        sd_byte_valid = 1'b0;
        avail_model = 1'b1;
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < max_cycles) begin
            @(posedge CLOCK_50);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, %0d reads outstanding, errors %0d",
                 cycle_count, exp_q.size(), err_count);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        int i;
        logic [31:0] addr;
        void'($urandom(32'h3b9477c9));
        KEY0 = 1'b0;
        bus_address = '0;
        bus_write_data = '0;
        bus_write_enable = 1'b0;
        bus_read_enable = 1'b0;
        key_valid = 1'b0;
        key_ascii = 8'd0;
        irq_ack = 1'b0;
        sd_byte_valid = 1'b0;
        sd_byte = 8'd0;
        $readmemh("ram_init.hex", ram_model, 0, ram_init_words - 1);
        key_model = 8'd0;
        avail_model = 1'b0;
        exp_irq = 4'd0;
        exp_uart_data = 8'd0;
        exp_sector = '0;
        exp_data = '0;
        err_count = 0;
        reads_done = 0;
        wait_cycles(16);
        KEY0 = 1'b1;

        // Preloaded words and idle peripherals
        for (i = 0; i < ram_init_words; i++) begin
            drive_read(ram_base + 32'(4 * i));
        end
        drive_read(key_addr);
        drive_read(sd_avail_reg);

        // Each write read back on the very next cycle
        for (i = 0; i < ram_pairs; i++) begin
            addr = ram_base + 32'(4 * $urandom_range(ram_words - 1, 0));
            drive_write(addr, {$urandom, $urandom});
            drive_read(addr);
        end
        drive_read(32'h0000_8004);
        drive_read(32'h0000_2000);
        for (i = 0; i < 8; i++) begin
            drive_read(32'h0001_0000 | ($urandom & 32'h0000_fffc));
        end

        pulse_key(1'b1, 8'h41, 1'b0);
        drive_read(key_addr);
        wait_cycles(2);
        pulse_key(1'b0, 8'd0, 1'b1);
        pulse_key(1'b1, 8'd0, 1'b0);
        // Zero code leaves the stored key alone
        drive_read(key_addr);
        wait_cycles(2);
        pulse_key(1'b1, 8'h7a, 1'b1);
        drive_read(key_addr);
        pulse_key(1'b0, 8'd0, 1'b1);

        drive_write(uart_addr, {$urandom, $urandom});
        wait_cycles(3);
        drive_write(uart_addr, 64'h0000_0000_0000_01a5);
        wait_cycles(3);

        // Sector select, read start, then a full sector streamed in
        drive_write(sd_addr_reg, {$urandom, $urandom});
        wait_cycles(3);
        drive_write(sd_read_reg, 64'd1);
        wait_cycles(4);
        stream_sector();
        wait_cycles(2);
        drive_read(sd_avail_reg);
        for (i = 0; i < buf_reads; i++) begin
            drive_read(sd_buf_base + 32'($urandom_range(sd_buf_bytes - 1, 0)));
        end
        drive_write(sd_read_reg, 64'd1);
        wait_cycles(4);
        drive_read(sd_avail_reg);

        while (exp_q.size() != 0) begin
            @(posedge CLOCK_50);
        end
        wait_cycles(4);
        $display("Reads checked %0d, errors %0d", reads_done, err_count);
        if (err_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* ram_init.hex */
// RAM words 0 to 15, one 32-bit hex word per line
0000_0013
1234_5678
89ab_cdef
dead_beef
0f0f_0f0f
f0f0_f0f0
5555_aaaa
aaaa_5555
0000_0001
8000_0000
7fff_ffff
ffff_fffe
0102_0304
a5a5_5a5a
c001_d00d
0000_ffff

/* board_bus.f */
bus_map_pkg.sv
bus_txn_pkg.sv
bus_stage_if.sv
bus_decode_stage.sv
bus_access_stage.sv
sd_sector_buffer.sv
key_event_latch.sv
bus_response_stage.sv
board_bus.sv
tb_board_bus.sv

/* run_sim.sh */
#!/bin/bash
# Build board_bus with its testbench under Verilator, then run it
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_board_bus -f board_bus.f -o tb_board_bus \
    > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/tb_board_bus > sim.log 2>&1
cat sim.log

grep -q "Simulation FAILED" sim.log && { echo "Run failed, see sim.log"; exit 1; }
grep -q "Simulation PASSED" sim.log || { echo "Run gave no result, see sim.log"; exit 1; }
exit 0
